// ==== asym_ram/asym_ram_2p.sv ====
`timescale 1ns/1ps
`default_nettype none

module asym_ram_2p
   import fifo_pkg::*;
#(
   parameter int W_DATA_W = 8,
   parameter int R_DATA_W = 32,
   parameter int ADDR_W   = 6,
   // address width of the narrow side is ADDR_W, the wide side loses the lane bits
   localparam int MAXDATA_W = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MINDATA_W = (W_DATA_W < R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MINADDR_W = ADDR_W - $clog2(MAXDATA_W / MINDATA_W),
   localparam int W_ADDR_W  = (W_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W,
   localparam int R_ADDR_W  = (R_DATA_W == MAXDATA_W) ? MINADDR_W : ADDR_W
) (
   input  wire logic                r_clk_i,

   // write port
   input  wire ram_wr_t             wr_i,
   input  wire logic [W_ADDR_W-1:0] w_addr_i,

   // read port
   input  wire logic                r_en_i,
   input  wire logic [R_ADDR_W-1:0] r_addr_i,
   output logic      [R_DATA_W-1:0] r_data_o
);

   // number of symmetric banks
   localparam int N = MAXDATA_W / MINDATA_W;

   // write struct carries one sample, a wider write port sees it zero-extended
   logic [W_DATA_W-1:0]  w_data;

   // bank buses
   logic [N-1:0]         en_wr;
   logic [MINDATA_W-1:0] data_wr [N];
   logic [MINADDR_W-1:0] addr_wr [N];
   logic [MINDATA_W-1:0] data_rd [N];
   logic [MINADDR_W-1:0] addr_rd;

   assign w_data = W_DATA_W'(wr_i.data);

   for (genvar i = 0; i < N; i++) begin : g_bank
      lane_bank_ram #(
         .DATA_W(MINDATA_W),
         .ADDR_W(MINADDR_W)
      ) u_bank (
         .r_clk_i  (r_clk_i),
         .w_en_i   (en_wr[i]),
         .w_addr_i (addr_wr[i]),
         .w_data_i (data_wr[i]),
         .r_en_i   (r_en_i),
         .r_addr_i (addr_rd),
         .r_data_o (data_rd[i])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wr_wide
      localparam int SEL_W = R_ADDR_W - W_ADDR_W;

      logic [SEL_W-1:0] r_sel_q;

      // every bank takes its own slice of the wide word
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = wr_i.en;
            data_wr[j] = w_data[j*MINDATA_W +: MINDATA_W];
            addr_wr[j] = w_addr_i;
         end
      end

      assign addr_rd = r_addr_i[R_ADDR_W-1 -: W_ADDR_W];

      // lane select has to line up with the registered bank output
      always_ff @(posedge r_clk_i) begin
         if (r_en_i) begin
            r_sel_q <= r_addr_i[SEL_W-1:0];
         end
      end

      assign r_data_o = data_rd[r_sel_q];

   end else if (W_DATA_W < R_DATA_W) begin : g_rd_wide
      localparam int SEL_W = W_ADDR_W - R_ADDR_W;

      // low address bits pick the lane, upper bits the row
      always_comb begin
         for (int j = 0; j < N; j++) begin
            en_wr[j]   = wr_i.en && (w_addr_i[SEL_W-1:0] == SEL_W'(j));
            data_wr[j] = w_data;
            addr_wr[j] = w_addr_i[W_ADDR_W-1 -: R_ADDR_W];
         end
      end

      assign addr_rd = r_addr_i;

      // lane k lands at bits k*MINDATA_W upward
      always_comb begin
         for (int k = 0; k < N; k++) begin
            r_data_o[k*MINDATA_W +: MINDATA_W] = data_rd[k];
         end
      end

   end else begin : g_equal
      // single bank, straight through
      assign en_wr[0]   = wr_i.en;
      assign data_wr[0] = w_data;
      assign addr_wr[0] = w_addr_i;
      assign addr_rd    = r_addr_i;
      assign r_data_o   = data_rd[0];
   end

endmodule

`default_nettype wire

// ==== asym_ram/lane_bank_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lane_bank_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  wire logic              r_clk_i,

   // write port
   input  wire logic              w_en_i,
   input  wire logic [ADDR_W-1:0] w_addr_i,
   input  wire logic [DATA_W-1:0] w_data_i,

   // read port
   input  wire logic              r_en_i,
   input  wire logic [ADDR_W-1:0] r_addr_i,
   output logic      [DATA_W-1:0] r_data_o
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge r_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // output only updates on a read, holds otherwise
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

endmodule

`default_nettype wire

// ==== common/fifo_pkg.sv ====
`default_nettype none

package fifo_pkg;

   import mem_geom_pkg::*;

   // fill status seen by both sides of the FIFO
   typedef struct packed {
      logic full;    // level equals the depth in samples
      logic empty;   // no complete word stored
   } fifo_status_t;

   // write request into the RAM
   // address goes on its own port, its width follows ADDR_W
   typedef struct packed {
      logic    en;
      narrow_t data;
   } ram_wr_t;

endpackage

`default_nettype wire

// ==== common/mem_geom_pkg.sv ====
`default_nettype none

package mem_geom_pkg;

   // sample and word widths
   localparam int NARROW_W = 8;
   localparam int WIDE_W   = 32;

   // samples per word, also the number of byte lanes in the RAM
   localparam int LANES = WIDE_W / NARROW_W;

   // one pushed sample
   typedef logic [NARROW_W-1:0] narrow_t;

   // one popped word, first sample in bits 7:0
   typedef logic [WIDE_W-1:0] wide_t;

endpackage

`default_nettype wire

// ==== compile.f ====
common/mem_geom_pkg.sv
common/fifo_pkg.sv
asym_ram/lane_bank_ram.sv
asym_ram/asym_ram_2p.sv
rtl/fifo_wr_side.sv
rtl/fifo_rd_side.sv
rtl/fifo_level.sv
rtl/pack_fifo_top.sv
test/pack_fifo_assertions.sv
test/pack_fifo_tb.sv

// ==== rtl/fifo_level.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_level
   import mem_geom_pkg::*, fifo_pkg::*;
#(
   parameter int ADDR_W = 6
) (
   input  wire logic          r_clk_i,
   input  wire logic          reset_i,

   input  wire logic          push_go_i,
   input  wire logic          pop_go_i,

   output fifo_status_t       status_o,
   output logic [ADDR_W:0]    level_o
);

   // depth in samples
   localparam int DEPTH = 2**ADDR_W;

   logic [ADDR_W:0] lvl_q;
   logic [ADDR_W:0] lvl_d;
   fifo_status_t    status_q;

   // +1 per sample in, -LANES per word out
   always_comb begin
      lvl_d = lvl_q + (ADDR_W+1)'(push_go_i);
      if (pop_go_i) begin
         lvl_d = lvl_d - (ADDR_W+1)'(LANES);
      end
   end

   // flags come from the next count so they are exact right after the edge
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         lvl_q          <= '0;
         status_q.full  <= 1'b0;
         status_q.empty <= 1'b1;
      end else begin
         lvl_q          <= lvl_d;
         status_q.full  <= (lvl_d == (ADDR_W+1)'(DEPTH));
         status_q.empty <= (lvl_d < (ADDR_W+1)'(LANES));
      end
   end

   assign status_o = status_q;
   assign level_o  = lvl_q;

endmodule

`default_nettype wire

// ==== rtl/fifo_rd_side.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_side
   import mem_geom_pkg::*, fifo_pkg::*;
#(
   parameter int ADDR_W = 6,
   localparam int RPTR_W = ADDR_W - $clog2(LANES)
) (
   input  wire logic              r_clk_i,
   input  wire logic              reset_i,

   input  wire logic              pop_i,
   input  wire fifo_status_t      status_i,

   output logic                   r_en_o,
   output logic      [RPTR_W-1:0] r_addr_o,
   output logic                   pop_go_o,
   output logic                   pop_valid_o
);

   logic              pop_ok;
   logic [RPTR_W-1:0] r_ptr_q;
   logic              pop_valid_q;

   // only whole words can leave, empty already covers a partial word
   assign pop_ok = pop_i && !status_i.empty;

   // word pointer
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         r_ptr_q <= '0;
      end else if (pop_ok) begin
         r_ptr_q <= r_ptr_q + 1'b1;
      end
   end

   // bank output is registered, so data shows up one cycle after the accept
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         pop_valid_q <= 1'b0;
      end else begin
         pop_valid_q <= pop_ok;
      end
   end

   assign r_en_o      = pop_ok;
   assign r_addr_o    = r_ptr_q;
   assign pop_go_o    = pop_ok;
   assign pop_valid_o = pop_valid_q;

endmodule

`default_nettype wire

// ==== rtl/fifo_wr_side.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_side
   import mem_geom_pkg::*, fifo_pkg::*;
#(
   parameter int ADDR_W = 6
) (
   input  wire logic              r_clk_i,
   input  wire logic              reset_i,

   input  wire logic              push_i,
   input  wire narrow_t           push_data_i,
   input  wire fifo_status_t      status_i,

   output ram_wr_t                wr_o,
   output logic      [ADDR_W-1:0] w_addr_o,
   output logic                   push_go_o
);

   logic              push_ok;
   logic [ADDR_W-1:0] w_ptr_q;

   // a push into a full FIFO is dropped
   assign push_ok = push_i && !status_i.full;

   // sample pointer, wraps at the end of the RAM
   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         w_ptr_q <= '0;
      end else if (push_ok) begin
         w_ptr_q <= w_ptr_q + 1'b1;
      end
   end

   // write happens on the same edge that accepts the push
   assign wr_o.en   = push_ok;
   assign wr_o.data = push_data_i;
   assign w_addr_o  = w_ptr_q;
   assign push_go_o = push_ok;

endmodule

`default_nettype wire

// ==== rtl/pack_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pack_fifo_top
   import mem_geom_pkg::*, fifo_pkg::*;
#(
   parameter int ADDR_W = 6
) (
   input  wire logic          r_clk_i,
   input  wire logic          reset_i,

   input  wire logic          push_i,
   input  wire narrow_t       push_data_i,
   input  wire logic          pop_i,

   output wide_t              pop_data_o,
   output logic               pop_valid_o,
   output fifo_status_t       status_o,
   output logic [ADDR_W:0]    level_o
);

   // word address width on the read side
   localparam int RPTR_W = ADDR_W - $clog2(LANES);

   fifo_status_t      status;
   ram_wr_t           wr;
   logic [ADDR_W-1:0] w_addr;
   logic              push_go;
   logic              r_en;
   logic [RPTR_W-1:0] r_addr;
   logic              pop_go;

   fifo_wr_side #(
      .ADDR_W(ADDR_W)
   ) u_wr_side (
      .r_clk_i     (r_clk_i),
      .reset_i     (reset_i),
      .push_i      (push_i),
      .push_data_i (push_data_i),
      .status_i    (status),
      .wr_o        (wr),
      .w_addr_o    (w_addr),
      .push_go_o   (push_go)
   );

   // narrow write, wide read
   asym_ram_2p #(
      .W_DATA_W(NARROW_W),
      .R_DATA_W(WIDE_W),
      .ADDR_W  (ADDR_W)
   ) u_ram (
      .r_clk_i  (r_clk_i),
      .wr_i     (wr),
      .w_addr_i (w_addr),
      .r_en_i   (r_en),
      .r_addr_i (r_addr),
      .r_data_o (pop_data_o)
   );

   fifo_level #(
      .ADDR_W(ADDR_W)
   ) u_level (
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .push_go_i (push_go),
      .pop_go_i  (pop_go),
      .status_o  (status),
      .level_o   (level_o)
   );

   fifo_rd_side #(
      .ADDR_W(ADDR_W)
   ) u_rd_side (
      .r_clk_i     (r_clk_i),
      .reset_i     (reset_i),
      .pop_i       (pop_i),
      .status_i    (status),
      .r_en_o      (r_en),
      .r_addr_o    (r_addr),
      .pop_go_o    (pop_go),
      .pop_valid_o (pop_valid_o)
   );

   assign status_o = status;

endmodule

`default_nettype wire

// ==== test/pack_fifo_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module pack_fifo_assertions
   import mem_geom_pkg::*, fifo_pkg::*;
#(
   parameter int ADDR_W = 6
) (
   input wire logic            r_clk_i,
   input wire logic            reset_i,
   input wire logic            pop_i,
   input wire logic            pop_valid_i,
   input wire fifo_status_t    status_i,
   input wire logic [ADDR_W:0] level_i
);

   int unsigned fail_count = 0;
   logic        pop_ok;

   // same accept rule as the read side
   assign pop_ok = pop_i && !status_i.empty;

   flags_exclusive: assert property (@(posedge r_clk_i) disable iff (reset_i)
      !(status_i.full && status_i.empty))
   else begin
      $error("full and empty are both high");
      fail_count++;
   end

   valid_after_pop: assert property (@(posedge r_clk_i) disable iff (reset_i)
      pop_ok |=> pop_valid_i)
   else begin
      $error("no pop_valid one cycle after an accepted pop");
      fail_count++;
   end

   no_stray_valid: assert property (@(posedge r_clk_i) disable iff (reset_i)
      pop_valid_i |-> $past(pop_ok))
   else begin
      $error("pop_valid without an accepted pop the cycle before");
      fail_count++;
   end

   level_in_range: assert property (@(posedge r_clk_i) disable iff (reset_i)
      level_i <= (ADDR_W+1)'(2**ADDR_W))
   else begin
      $error("level above the FIFO depth");
      fail_count++;
   end

endmodule

bind pack_fifo_top pack_fifo_assertions #(
   .ADDR_W(ADDR_W)
) u_asserts (
   .r_clk_i     (r_clk_i),
   .reset_i     (reset_i),
   .pop_i       (pop_i),
   .pop_valid_i (pop_valid_o),
   .status_i    (status_o),
   .level_i     (level_o)
);

`default_nettype wire

// ==== test/pack_fifo_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pack_fifo_tb
   import mem_geom_pkg::*, fifo_pkg::*;
();

   localparam int ADDR_W     = 6;
   localparam int DEPTH      = 2**ADDR_W;
   localparam int MAX_CYCLES = 2000;

   logic              r_clk;
   logic              reset;
   logic              push;
   narrow_t           push_data;
   logic              pop;
   wide_t             pop_data;
   logic              pop_valid;
   fifo_status_t      status;
   logic [ADDR_W:0]   level;

   // reference model with the oldest sample at the front
   narrow_t           model_q[$];
   logic              pend_pop;
   logic              have_word;
   wide_t             last_word;
   string             test_name;
   int                cycles;
   integer            seed;

   pack_fifo_top #(
      .ADDR_W(ADDR_W)
   ) dut0 (
      .r_clk_i     (r_clk),
      .reset_i     (reset),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .pop_data_o  (pop_data),
      .pop_valid_o (pop_valid),
      .status_o    (status),
      .level_o     (level)
   );

   initial begin
      r_clk = 1'b0;
      forever #4 r_clk = ~r_clk;
   end

   always @(posedge r_clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
         fail_now();
      end
   end

   task automatic fail_now();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input wide_t exp, input wide_t act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %h, actual %h", test_name, what, exp, act);
         fail_now();
      end
   endtask

   task automatic check_status(input fifo_status_t exp, input fifo_status_t act);
      if (act !== exp) begin
         $display("MISMATCH %s status {full,empty}: expected %b, actual %b",
                  test_name, exp, act);
         fail_now();
      end
   endtask

   task automatic check_level(input string what, input logic [ADDR_W:0] exp,
                              input logic [ADDR_W:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, exp, act);
         fail_now();
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s %s: expected %b, actual %b", test_name, what, exp, act);
         fail_now();
      end
   endtask

   // drive one cycle of strobes and check the outcome of the last edge
   // then advance the model by what this cycle will accept
   task automatic run_cycle(input logic p, input narrow_t d, input logic q);
      fifo_status_t exp_st;
      logic         push_ok;
      logic         pop_ok;
      wide_t        word;
      @(posedge r_clk);
      push      <= p;
      push_data <= d;
      pop       <= q;
      @(negedge r_clk);
      exp_st.full  = (model_q.size() == DEPTH);
      exp_st.empty = (model_q.size() < LANES);
      check_status(exp_st, status);
      check_level("level", (ADDR_W+1)'(model_q.size()), level);
      check_flag("pop_valid", pend_pop, pop_valid);
      if (have_word) begin
         check_word("pop_data", last_word, pop_data);
      end
      push_ok = p && (model_q.size() != DEPTH);
      pop_ok  = q && (model_q.size() >= LANES);
      if (pop_ok) begin
         word = '0;
         for (int k = 0; k < LANES; k++) begin
            word[k*NARROW_W +: NARROW_W] = model_q.pop_front();
         end
         last_word = word;
         have_word = 1'b1;
      end
      if (push_ok) begin
         model_q.push_back(d);
      end
      pend_pop = pop_ok;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) run_cycle(1'b0, '0, 1'b0);
   endtask

   task automatic drain_words();
      while (model_q.size() >= LANES) begin
         run_cycle(1'b0, '0, 1'b1);
      end
      idle_cycles(2);
   endtask

   task automatic test_reset();
      test_name = "reset";
      idle_cycles(3);
      check_level("level after reset", '0, level);
      check_flag("empty after reset", 1'b1, status.empty);
   endtask

   task automatic test_one_word();
      test_name = "one_word";
      run_cycle(1'b1, 8'h11, 1'b0);
      run_cycle(1'b1, 8'h22, 1'b0);
      run_cycle(1'b1, 8'h33, 1'b0);
      run_cycle(1'b1, 8'h44, 1'b0);
      run_cycle(1'b0, '0, 1'b1);
      idle_cycles(2);
      // first sample in the low byte
      check_word("packed word", 32'h4433_2211, pop_data);
   endtask

   task automatic test_fill_drain();
      test_name = "fill_drain";
      repeat (DEPTH) run_cycle(1'b1, narrow_t'($random(seed)), 1'b0);
      idle_cycles(1);
      check_level("level when full", (ADDR_W+1)'(DEPTH), level);
      check_flag("full", 1'b1, status.full);
      // one more sample is dropped
      run_cycle(1'b1, 8'hee, 1'b0);
      idle_cycles(1);
      check_level("level after dropped push", (ADDR_W+1)'(DEPTH), level);
      repeat (DEPTH / LANES) run_cycle(1'b0, '0, 1'b1);
      idle_cycles(2);
      check_level("level after drain", '0, level);
   endtask

   task automatic test_pop_empty();
      test_name = "pop_empty";
      run_cycle(1'b0, '0, 1'b1);
      idle_cycles(2);
      run_cycle(1'b1, 8'ha1, 1'b0);
      run_cycle(1'b1, 8'ha2, 1'b0);
      run_cycle(1'b1, 8'ha3, 1'b0);
      // a pop on a partial word is not taken
      run_cycle(1'b0, '0, 1'b1);
      idle_cycles(2);
      check_level("level with partial word", 7'd3, level);
   endtask

   task automatic test_push_pop_same();
      logic [ADDR_W:0] lvl_before;
      test_name = "push_pop_same";
      for (int i = 0; i < 5; i++) begin
         run_cycle(1'b1, narrow_t'(8'hb0 + i), 1'b0);
      end
      idle_cycles(1);
      lvl_before = (ADDR_W+1)'(model_q.size());
      run_cycle(1'b1, 8'hc5, 1'b1);
      idle_cycles(1);
      check_level("level after push and pop", lvl_before - 7'd3, level);
      drain_words();
   endtask

   task automatic test_random_traffic();
      logic    p;
      logic    q;
      narrow_t d;
      test_name = "random_traffic";
      // first half fills towards full and the second half drains
      for (int i = 0; i < 500; i++) begin
         p = ($random(seed) & 3) != 0;
         d = narrow_t'($random(seed));
         if (i < 250) begin
            q = ($random(seed) & 7) == 0;
         end else begin
            q = ($random(seed) & 1) == 1;
         end
         run_cycle(p, d, q);
      end
      drain_words();
   endtask

   initial begin
      seed      = 32'h227d_aa96;
      cycles    = 0;
      pend_pop  = 1'b0;
      have_word = 1'b0;
      last_word = '0;
      test_name = "init";
      reset     = 1'b1;
      push      = 1'b0;
      push_data = '0;
      pop       = 1'b0;
      repeat (2) @(posedge r_clk);
      reset <= 1'b0;

      test_reset();
      test_one_word();
      test_fill_drain();
      test_pop_empty();
      test_push_pop_same();
      test_random_traffic();
      idle_cycles(2);

      if (dut0.u_asserts.fail_count == 0) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("assertions failed %0d times", dut0.u_asserts.fail_count);
         fail_now();
      end
   end

endmodule

`default_nettype wire
